// ==== list.f ====
rtl/cp0_pkg.sv
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/regfile.sv
rtl/execute_stage.sv
rtl/mem_stage.sv
rtl/cp0_timer.sv
rtl/openmips.sv
testbench/tb_openmips.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_openmips
RTL_TOP   ?= openmips
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall
SOURCES   ?= $(shell cat $(FILELIST))
RTL_SRCS  ?= $(filter rtl/%,$(SOURCES))
PASS_MSG  ?= All tests passed!
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/tb_openmips.sv ====
`default_nettype none

module tb_openmips
    import cpu_pkg::*;
    import cp0_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          IMEM_WORDS   = 512;
    localparam int          RESET_CYCLES = 10;
    localparam int          RANDOM_LEN   = 200;
    localparam int          LATE_IDX     = 100;
    localparam logic [15:0] COUNT_START  = 16'h0100;

    logic              clk = 1'b0;
    logic              rst_n_i;
    logic [INST_W-1:0] if_data_i;
    logic [REG_W-1:0]  if_addr_o;
    logic              if_ce_o;
    logic [REG_W-1:0]  mem_addr_o;
    logic [REG_W-1:0]  mem_data_o;
    logic              mem_we_o;
    logic [3:0]        mem_sel_o;
    logic              mem_ce_o;
    logic              timer_int_o;

    logic [31:0] imem [0:IMEM_WORDS-1];
    logic [31:0] model_regs [0:31];
    logic [31:0] prog [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          sw_cycles [$];
    int          cycle = 0;
    int          checks = 0;
    int          errors = 0;
    logic        prev_ce = 1'b0;
    logic [31:0] prev_addr = '0;

    openmips dut0 (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .if_data_i   (if_data_i),
        .if_addr_o   (if_addr_o),
        .if_ce_o     (if_ce_o),
        .mem_addr_o  (mem_addr_o),
        .mem_data_o  (mem_data_o),
        .mem_we_o    (mem_we_o),
        .mem_sel_o   (mem_sel_o),
        .mem_ce_o    (mem_ce_o),
        .timer_int_o (timer_int_o)
    );

    always #10 clk = ~clk;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic require(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("ERROR: %s", what);
        end
    endtask

    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr < 32'(IMEM_WORDS * 4)) begin
            return imem[addr[10:2]];
        end
        return 32'h0;
    endfunction

    function automatic logic [31:0] itype(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] rtype(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] mtc0(input logic [4:0] rt, input logic [4:0] rd);
        return {OP_COP0, COP0_MT, rt, rd, 11'd0};
    endfunction

    task automatic check_store();
        compare_value("mem_ce_o", {31'd0, mem_ce_o}, 32'd1);
        if (exp_addr.size() == 0) begin
            require(1'b0, "store issued when none was expected");
        end else begin
            compare_value("mem_addr_o", mem_addr_o, exp_addr.pop_front());
            compare_value("mem_data_o", mem_data_o, exp_data.pop_front());
            compare_value("mem_sel_o", {28'h0, mem_sel_o}, 32'h0000_000f);
        end
        if (sw_cycles.size() == 0) begin
            require(1'b0, "store issued without a SW in the pipeline");
        end else begin
            compare_value("store cycle", 32'(cycle), 32'(sw_cycles.pop_front() + 3));
        end
    endtask

    // Drive fetch data at the falling edge and watch the buses
    task automatic step_cycle();
        @(negedge clk);
        cycle++;
        if_data_i = fetch_word(if_addr_o);
        require(mem_we_o || !mem_ce_o, "mem_ce_o high while mem_we_o is low");
        if (if_ce_o && prev_ce) begin
            compare_value("if_addr_o", if_addr_o, prev_addr + 32'd4);
        end
        prev_ce   = if_ce_o;
        prev_addr = if_addr_o;
        if (mem_we_o) begin
            check_store();
        end
        if (if_ce_o && if_data_i[31:26] == OP_SW) begin
            sw_cycles.push_back(cycle);
        end
    endtask

    task automatic check_quiet(input logic with_fetch);
        if (with_fetch) begin
            compare_value("if_ce_o", {31'd0, if_ce_o}, 32'd0);
        end
        compare_value("mem_ce_o", {31'd0, mem_ce_o}, 32'd0);
        compare_value("mem_we_o", {31'd0, mem_we_o}, 32'd0);
        compare_value("timer_int_o", {31'd0, timer_int_o}, 32'd0);
    endtask

    // Architectural model stepping one instruction at a time
    task automatic model_exec(input logic [31:0] inst);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] zext;
        logic [31:0] val;
        logic [4:0]  dest;
        logic        we;
        a    = model_regs[inst[25:21]];
        b    = model_regs[inst[20:16]];
        sext = {{16{inst[15]}}, inst[15:0]};
        zext = {16'h0000, inst[15:0]};
        dest = inst[20:16];
        we   = 1'b1;
        val  = '0;
        case (inst[31:26])
            OP_ORI:   val = a | zext;
            OP_ANDI:  val = a & zext;
            OP_XORI:  val = a ^ zext;
            OP_ADDIU: val = a + sext;
            OP_LUI:   val = {inst[15:0], 16'h0000};
            OP_SW: begin
                we = 1'b0;
                exp_addr.push_back(a + sext);
                exp_data.push_back(b);
            end
            OP_SPECIAL: begin
                dest = inst[15:11];
                case (inst[5:0])
                    FN_ADDU: val = a + b;
                    FN_SUBU: val = a - b;
                    FN_AND:  val = a & b;
                    FN_OR:   val = a | b;
                    FN_XOR:  val = a ^ b;
                    FN_SLT:  val = {31'd0, $signed(a) < $signed(b)};
                    default: we = 1'b0;
                endcase
            end
            default: we = 1'b0;
        endcase
        if (we && dest != 5'd0) begin
            model_regs[dest] = val;
        end
    endtask

    task automatic emit(input logic [31:0] inst);
        prog.push_back(inst);
        model_exec(inst);
    endtask

    // Back-to-back dependencies hit ex tap, mem tap and write-through
    task automatic build_directed();
        emit(itype(OP_LUI, 5'd0, 5'd1, 16'h8001));
        emit(itype(OP_ORI, 5'd1, 5'd1, 16'h1234));
        emit(itype(OP_SW, 5'd0, 5'd1, 16'h0100));
        emit(itype(OP_ADDIU, 5'd0, 5'd2, 16'hfffb));
        emit(rtype(FN_ADDU, 5'd1, 5'd2, 5'd3));
        emit(itype(OP_SW, 5'd0, 5'd3, 16'h0104));
        emit(rtype(FN_SUBU, 5'd3, 5'd2, 5'd4));
        emit(itype(OP_SW, 5'd3, 5'd4, 16'h0010));
        emit(rtype(FN_XOR, 5'd4, 5'd1, 5'd5));
        emit(rtype(FN_AND, 5'd5, 5'd3, 5'd6));
        emit(rtype(FN_OR, 5'd6, 5'd5, 5'd7));
        emit(itype(OP_SW, 5'd0, 5'd5, 16'h0108));
        emit(itype(OP_SW, 5'd0, 5'd6, 16'h010c));
        emit(itype(OP_SW, 5'd0, 5'd7, 16'h0110));
        emit(rtype(FN_SLT, 5'd2, 5'd1, 5'd8));
        emit(rtype(FN_SLT, 5'd1, 5'd2, 5'd9));
        emit(itype(OP_SW, 5'd0, 5'd8, 16'h0114));
        emit(itype(OP_SW, 5'd0, 5'd9, 16'h0118));
        emit(itype(OP_ANDI, 5'd1, 5'd10, 16'hf0f0));
        emit(itype(OP_XORI, 5'd10, 5'd10, 16'hffff));
        emit(itype(OP_ADDIU, 5'd10, 5'd11, 16'h8000));
        emit(itype(OP_SW, 5'd11, 5'd10, 16'hfffc));
        emit(itype(OP_SW, 5'd0, 5'd0, 16'h0120));
    endtask

    task automatic build_random();
        int          kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        for (int i = 0; i < RANDOM_LEN; i++) begin
            kind = int'($urandom_range(0, 13));
            rs   = 5'($urandom_range(1, 8));
            rt   = 5'($urandom_range(1, 8));
            rd   = 5'($urandom_range(1, 8));
            imm  = 16'($urandom);
            case (kind)
                0:       emit(itype(OP_ORI, rs, rd, imm));
                1:       emit(itype(OP_ANDI, rs, rd, imm));
                2:       emit(itype(OP_XORI, rs, rd, imm));
                3:       emit(itype(OP_ADDIU, rs, rd, imm));
                4:       emit(itype(OP_LUI, 5'd0, rd, imm));
                5:       emit(rtype(FN_ADDU, rs, rt, rd));
                6:       emit(rtype(FN_SUBU, rs, rt, rd));
                7:       emit(rtype(FN_AND, rs, rt, rd));
                8:       emit(rtype(FN_OR, rs, rt, rd));
                9:       emit(rtype(FN_XOR, rs, rt, rd));
                10:      emit(rtype(FN_SLT, rs, rt, rd));
                default: emit(itype(OP_SW, rs, rt, imm));
            endcase
        end
    endtask

    task automatic build_timer();
        emit(itype(OP_ORI, 5'd0, 5'd1, COUNT_START));
        emit(itype(OP_ORI, 5'd0, 5'd2, COUNT_START + 16'd40));
        emit(itype(OP_ORI, 5'd0, 5'd3, 16'h7000));
        emit(mtc0(5'd1, CP0_COUNT));
        emit(mtc0(5'd2, CP0_COMPARE));
        while (prog.size() < LATE_IDX) begin
            emit(32'h0);
        end
        emit(mtc0(5'd3, CP0_COMPARE));
    endtask

    task automatic load_program(input int which);
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        sw_cycles.delete();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        case (which)
            0:       build_directed();
            1:       build_random();
            default: build_timer();
        endcase
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
        end
    endtask

    task automatic restart(input int which);
        rst_n_i = 1'b0;
        for (int c = 0; c < RESET_CYCLES; c++) begin
            step_cycle();
            check_quiet(1'b1);
            if (c == 0) begin
                load_program(which);
            end
        end
        rst_n_i = 1'b1;
        check_quiet(1'b1);
        compare_value("if_addr_o", if_addr_o, 32'h0);
        step_cycle();
        check_quiet(1'b0);
        compare_value("if_addr_o", if_addr_o, 32'h0);
    endtask

    task automatic drain_stores(input int limit);
        int n;
        n = 0;
        while (exp_addr.size() != 0 && n < limit) begin
            step_cycle();
            n++;
        end
        require(exp_addr.size() == 0, "timed out waiting for the expected stores");
        // Empty the pipeline so a stray store still shows up
        repeat (8) step_cycle();
    endtask

    task automatic await_fetch(input logic [31:0] addr, input int limit);
        int n;
        n = 0;
        while (!(if_ce_o && if_addr_o == addr) && n < limit) begin
            step_cycle();
            n++;
        end
        require(if_ce_o && if_addr_o == addr, "timed out waiting for an instruction fetch");
    endtask

    task automatic timer_checks();
        int n;
        // Compare write sits at word 4
        await_fetch(32'd16, 40);
        n = 0;
        while (!timer_int_o && n < 60) begin
            step_cycle();
            n++;
        end
        require(timer_int_o, "timer_int_o did not rise within 60 cycles");
        for (int i = 0; i < 20; i++) begin
            step_cycle();
            require(timer_int_o, "timer_int_o fell before Compare was written again");
        end
        await_fetch(32'(LATE_IDX * 4), 200);
        n = 0;
        while (timer_int_o && n < 6) begin
            step_cycle();
            n++;
        end
        require(!timer_int_o, "timer_int_o not cleared by the later Compare write");
    endtask

    initial begin
        rst_n_i   = 1'b0;
        if_data_i = '0;
        void'($urandom(32'h5019_8f09));
        restart(0);
        drain_stores(200);
        restart(1);
        drain_stores(600);
        restart(2);
        timer_checks();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rtl/openmips.sv ====
`default_nettype none

module openmips
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,

    input  logic [INST_W-1:0] if_data_i,
    output logic [REG_W-1:0]  if_addr_o,
    output logic              if_ce_o,

    output logic [REG_W-1:0]  mem_addr_o,
    output logic [REG_W-1:0]  mem_data_o,
    output logic              mem_we_o,
    output logic [3:0]        mem_sel_o,
    output logic              mem_ce_o,

    output logic              timer_int_o
);

    logic [INST_W-1:0]     id_inst;
    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [REG_W-1:0]      rs_data;
    logic [REG_W-1:0]      rt_data;
    fwd_t                  ex_fwd;
    fwd_t                  mem_fwd;
    id_ex_t                id_ex;
    ex_mem_t               ex_mem;
    mem_wb_t               mem_wb;

    fetch_stage u_fetch (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .inst_i    (if_data_i),
        .pc_o      (if_addr_o),
        .ce_o      (if_ce_o),
        .id_inst_o (id_inst)
    );

    decode_stage u_decode (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .inst_i    (id_inst),
        .rs_addr_o (rs_addr),
        .rt_addr_o (rt_addr),
        .rs_data_i (rs_data),
        .rt_data_i (rt_data),
        .ex_fwd_i  (ex_fwd),
        .mem_fwd_i (mem_fwd),
        .id_ex_o   (id_ex)
    );

    // Write-back port driven straight from the mem/wb register
    regfile u_regfile (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .we_i     (mem_wb.we),
        .waddr_i  (mem_wb.waddr),
        .wdata_i  (mem_wb.result),
        .raddr1_i (rs_addr),
        .raddr2_i (rt_addr),
        .rdata1_o (rs_data),
        .rdata2_o (rt_data)
    );

    execute_stage u_execute (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .id_ex_i  (id_ex),
        .ex_fwd_o (ex_fwd),
        .ex_mem_o (ex_mem)
    );

    mem_stage u_mem (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ex_mem_i   (ex_mem),
        .mem_addr_o (mem_addr_o),
        .mem_data_o (mem_data_o),
        .mem_we_o   (mem_we_o),
        .mem_sel_o  (mem_sel_o),
        .mem_ce_o   (mem_ce_o),
        .mem_fwd_o  (mem_fwd),
        .mem_wb_o   (mem_wb)
    );

    cp0_timer u_cp0_timer (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cp0_wr_i    (mem_wb.cp0_wr),
        .timer_int_o (timer_int_o)
    );

endmodule

`default_nettype wire

// ==== rtl/cp0_timer.sv ====
`default_nettype none

module cp0_timer
    import cp0_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  cp0_wr_t cp0_wr_i,
    output logic    timer_int_o
);

    logic [CP0_W-1:0] count;
    logic [CP0_W-1:0] compare;
    logic             wr_count;
    logic             wr_compare;

    assign wr_count   = cp0_wr_i.we && (cp0_wr_i.addr == CP0_COUNT);
    assign wr_compare = cp0_wr_i.we && (cp0_wr_i.addr == CP0_COMPARE);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            count       <= '0;
            compare     <= '0;
            timer_int_o <= 1'b0;
        end else begin
            if (wr_count) begin
                count <= cp0_wr_i.data;
            end else begin
                count <= count + 1'b1;
            end
            // Writing Compare acknowledges the interrupt
            if (wr_compare) begin
                compare     <= cp0_wr_i.data;
                timer_int_o <= 1'b0;
            end else if (compare != '0 && count == compare) begin
                timer_int_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mem_stage.sv ====
`default_nettype none

module mem_stage
    import cpu_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n_i,
    input  ex_mem_t          ex_mem_i,
    output logic [REG_W-1:0] mem_addr_o,
    output logic [REG_W-1:0] mem_data_o,
    output logic             mem_we_o,
    output logic [3:0]       mem_sel_o,
    output logic             mem_ce_o,
    output fwd_t             mem_fwd_o,
    output mem_wb_t          mem_wb_o
);

    // Only full-word stores touch data memory
    assign mem_ce_o   = ex_mem_i.store;
    assign mem_we_o   = ex_mem_i.store;
    assign mem_sel_o  = ex_mem_i.store ? 4'b1111 : 4'b0000;
    assign mem_addr_o = ex_mem_i.st_addr;
    assign mem_data_o = ex_mem_i.st_data;

    assign mem_fwd_o.we     = ex_mem_i.we;
    assign mem_fwd_o.waddr  = ex_mem_i.waddr;
    assign mem_fwd_o.result = ex_mem_i.result;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            mem_wb_o.we        <= 1'b0;
            mem_wb_o.cp0_wr.we <= 1'b0;
        end else begin
            mem_wb_o.we     <= ex_mem_i.we;
            mem_wb_o.waddr  <= ex_mem_i.waddr;
            mem_wb_o.result <= ex_mem_i.result;
            mem_wb_o.cp0_wr <= ex_mem_i.cp0_wr;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`default_nettype none

module execute_stage
    import cpu_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    input  id_ex_t  id_ex_i,
    output fwd_t    ex_fwd_o,
    output ex_mem_t ex_mem_o
);

    logic [REG_W-1:0] result;
    ex_mem_t          ex_mem_d;

    always_comb begin
        case (id_ex_i.alu_op)
            ALU_OR:  result = id_ex_i.a | id_ex_i.b;
            ALU_AND: result = id_ex_i.a & id_ex_i.b;
            ALU_XOR: result = id_ex_i.a ^ id_ex_i.b;
            ALU_ADD: result = id_ex_i.a + id_ex_i.b;
            ALU_SUB: result = id_ex_i.a - id_ex_i.b;
            ALU_SLT: result = {{(REG_W-1){1'b0}}, $signed(id_ex_i.a) < $signed(id_ex_i.b)};
            ALU_LUI: result = {id_ex_i.b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    assign ex_fwd_o.we     = id_ex_i.we;
    assign ex_fwd_o.waddr  = id_ex_i.waddr;
    assign ex_fwd_o.result = result;

    always_comb begin
        ex_mem_d.waddr   = id_ex_i.waddr;
        ex_mem_d.we      = id_ex_i.we;
        ex_mem_d.result  = result;
        ex_mem_d.store   = id_ex_i.store;
        // Store address comes out of the same adder
        ex_mem_d.st_addr = result;
        ex_mem_d.st_data = id_ex_i.st_data;
        ex_mem_d.cp0_wr  = id_ex_i.cp0_wr;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_mem_o.we        <= 1'b0;
            ex_mem_o.store     <= 1'b0;
            ex_mem_o.cp0_wr.we <= 1'b0;
        end else begin
            ex_mem_o <= ex_mem_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
`default_nettype none

module regfile
    import cpu_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [REG_W-1:0]      wdata_i,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [REG_W-1:0]      rdata1_o,
    output logic [REG_W-1:0]      rdata2_o
);

    logic [REG_W-1:0] regs [0:(1<<REG_ADDR_W)-1];

    // Architectural state starts cleared
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < (1 << REG_ADDR_W); i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`default_nettype none

module decode_stage
    import cpu_pkg::*;
    import cp0_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic [INST_W-1:0]     inst_i,
    output logic [REG_ADDR_W-1:0] rs_addr_o,
    output logic [REG_ADDR_W-1:0] rt_addr_o,
    input  logic [REG_W-1:0]      rs_data_i,
    input  logic [REG_W-1:0]      rt_data_i,
    input  fwd_t                  ex_fwd_i,
    input  fwd_t                  mem_fwd_i,
    output id_ex_t                id_ex_o
);

    opcode_e               opcode;
    funct_e                funct;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_W-1:0]      imm_sext;
    logic [REG_W-1:0]      imm_zext;
    logic [REG_W-1:0]      rs_val;
    logic [REG_W-1:0]      rt_val;
    id_ex_t                id_ex_d;

    assign opcode    = opcode_e'(inst_i[31:26]);
    assign funct     = funct_e'(inst_i[5:0]);
    assign rs_addr_o = inst_i[25:21];
    assign rt_addr_o = inst_i[20:16];
    assign rd        = inst_i[15:11];
    assign imm_sext  = {{16{inst_i[15]}}, inst_i[15:0]};
    assign imm_zext  = {16'h0000, inst_i[15:0]};

    // Youngest producer wins; $0 never forwards
    function automatic logic [REG_W-1:0] operand(
        input logic [REG_ADDR_W-1:0] addr,
        input logic [REG_W-1:0]      rf_data
    );
        logic [REG_W-1:0] val;
        val = rf_data;
        if (addr != '0) begin
            if (ex_fwd_i.we && ex_fwd_i.waddr == addr) begin
                val = ex_fwd_i.result;
            end else if (mem_fwd_i.we && mem_fwd_i.waddr == addr) begin
                val = mem_fwd_i.result;
            end
        end
        return val;
    endfunction

    assign rs_val = operand(rs_addr_o, rs_data_i);
    assign rt_val = operand(rt_addr_o, rt_data_i);

    always_comb begin
        id_ex_d             = '0;
        id_ex_d.alu_op      = ALU_NOP;
        id_ex_d.a           = rs_val;
        id_ex_d.b           = rt_val;
        id_ex_d.st_data     = rt_val;
        id_ex_d.waddr       = rt_addr_o;
        id_ex_d.cp0_wr.addr = cp0_reg_e'(rd);
        id_ex_d.cp0_wr.data = rt_val;
        case (opcode)
            OP_SPECIAL: begin
                id_ex_d.waddr = rd;
                id_ex_d.we    = 1'b1;
                case (funct)
                    FN_ADDU: id_ex_d.alu_op = ALU_ADD;
                    FN_SUBU: id_ex_d.alu_op = ALU_SUB;
                    FN_AND:  id_ex_d.alu_op = ALU_AND;
                    FN_OR:   id_ex_d.alu_op = ALU_OR;
                    FN_XOR:  id_ex_d.alu_op = ALU_XOR;
                    FN_SLT:  id_ex_d.alu_op = ALU_SLT;
                    default: id_ex_d.we = 1'b0;
                endcase
            end
            OP_ORI: begin
                id_ex_d.alu_op = ALU_OR;
                id_ex_d.b      = imm_zext;
                id_ex_d.we     = 1'b1;
            end
            OP_ANDI: begin
                id_ex_d.alu_op = ALU_AND;
                id_ex_d.b      = imm_zext;
                id_ex_d.we     = 1'b1;
            end
            OP_XORI: begin
                id_ex_d.alu_op = ALU_XOR;
                id_ex_d.b      = imm_zext;
                id_ex_d.we     = 1'b1;
            end
            OP_ADDIU: begin
                id_ex_d.alu_op = ALU_ADD;
                id_ex_d.b      = imm_sext;
                id_ex_d.we     = 1'b1;
            end
            OP_LUI: begin
                id_ex_d.alu_op = ALU_LUI;
                id_ex_d.b      = imm_zext;
                id_ex_d.we     = 1'b1;
            end
            // Base plus offset through the adder
            OP_SW: begin
                id_ex_d.alu_op = ALU_ADD;
                id_ex_d.b      = imm_sext;
                id_ex_d.store  = 1'b1;
            end
            OP_COP0: begin
                id_ex_d.cp0_wr.we = (cop0_rs_e'(inst_i[25:21]) == COP0_MT);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_ex_o.we        <= 1'b0;
            id_ex_o.store     <= 1'b0;
            id_ex_o.cp0_wr.we <= 1'b0;
        end else begin
            id_ex_o <= id_ex_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`default_nettype none

module fetch_stage
    import cpu_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [INST_W-1:0] inst_i,
    output logic [REG_W-1:0]  pc_o,
    output logic              ce_o,
    output logic [INST_W-1:0] id_inst_o
);

    // PC holds at 0 until fetch is enabled, so address 0 is fetched once
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ce_o <= 1'b0;
            pc_o <= '0;
        end else begin
            ce_o <= 1'b1;
            if (ce_o) begin
                pc_o <= pc_o + PC_STEP;
            end
        end
    end

    // All-zero word is SLL $0, a NOP
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_inst_o <= '0;
        end else begin
            id_inst_o <= ce_o ? inst_i : '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    import cp0_pkg::*;

    localparam int REG_W      = 32;
    localparam int REG_ADDR_W = 5;
    localparam int INST_W     = 32;
    localparam int PC_STEP    = 4;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_COP0    = 6'h10,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_OR,
        ALU_AND,
        ALU_XOR,
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef struct packed {
        alu_op_e               alu_op;
        logic [REG_W-1:0]      a;
        logic [REG_W-1:0]      b;
        logic [REG_W-1:0]      st_data;
        logic [REG_ADDR_W-1:0] waddr;
        logic                  we;
        logic                  store;
        cp0_wr_t               cp0_wr;
    } id_ex_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] waddr;
        logic                  we;
        logic [REG_W-1:0]      result;
        logic                  store;
        logic [REG_W-1:0]      st_addr;
        logic [REG_W-1:0]      st_data;
        cp0_wr_t               cp0_wr;
    } ex_mem_t;

    typedef struct packed {
        logic [REG_ADDR_W-1:0] waddr;
        logic                  we;
        logic [REG_W-1:0]      result;
        cp0_wr_t               cp0_wr;
    } mem_wb_t;

    // Result tap fed back to decode
    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [REG_W-1:0]      result;
    } fwd_t;

endpackage

`default_nettype wire

// ==== rtl/cp0_pkg.sv ====
`default_nettype none

package cp0_pkg;

    localparam int CP0_W = 32;

    // Coprocessor 0 register numbers used by the timer
    typedef enum logic [4:0] {
        CP0_COUNT   = 5'd9,
        CP0_COMPARE = 5'd11
    } cp0_reg_e;

    // rs field of a COP0 instruction
    typedef enum logic [4:0] {
        COP0_MT = 5'd4
    } cop0_rs_e;

    typedef struct packed {
        logic             we;
        cp0_reg_e         addr;
        logic [CP0_W-1:0] data;
    } cp0_wr_t;

endpackage

`default_nettype wire
